// ==== include/machine_rom.svh ====
// machine description read by the host driver at boot
localparam logic [31:0] machine_rom_tbl [0:15] = '{
  32'h0004_0100,   // format version
  32'h0000_0020,   // noc address width
  32'h0000_0020,   // noc data width
  32'h0000_0010,   // pod tiles x
  32'h0000_0008,   // pod tiles y
  32'h0000_0001,   // pods x
  32'h0000_0001,   // pods y
  32'h0000_0008,   // cache ways
  32'h0000_0040,   // cache sets
  32'h0000_0010,   // cache line words
  32'h0000_0003,   // reset depth
  32'h0800_0000,   // dram window size
  32'h0000_0400,   // dmem words
  32'h0000_0400,   // icache entries
  32'h0000_0004,   // host queue depth
  32'hc0de_5e11    // signature
};

// ==== rtl/zynq_shell_pkg.sv ====
`default_nettype none

package zynq_shell_pkg;

  //////////////////////////////////////////////////////////////////////////
  // bus and register widths
  //////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] data_t;

  // matches the GP0 address width of the host bridge
  typedef logic [9:0]  csr_addr_t;

  // word index taken from paddr[4:2]
  typedef enum logic [2:0]
  {
    reg_sys_reset   = 3'd0,
    reg_dram_base   = 3'd1,
    reg_rom_addr    = 3'd2,
    reg_rom_data    = 3'd3,
    reg_host_req    = 3'd4,
    reg_mc_req      = 3'd5,
    reg_fifo_status = 3'd6
  } csr_reg_e;

  //////////////////////////////////////////////////////////////////////////
  // dram address mapping
  //////////////////////////////////////////////////////////////////////////

  typedef logic [31:0] dram_addr_t;
  typedef logic [27:0] cache_addr_t;
  typedef logic [2:0]  cache_id_t;

  // 128 MiB window
  localparam int dram_span_bits = 27;

  //////////////////////////////////////////////////////////////////////////
  // configuration rom
  //////////////////////////////////////////////////////////////////////////

  localparam int rom_els = 16;

  typedef logic [$clog2(rom_els)-1:0] rom_addr_t;

endpackage

`default_nettype wire

// ==== rtl/csr_fifo_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface csr_fifo_if
  #(parameter int fifo_depth_p = 4
  );

  import zynq_shell_pkg::*;

  localparam int lvl_w_lp = $clog2(fifo_depth_p+1);

  // req is push or pop depending on the queue direction
  logic                req;
  data_t               wdata;
  data_t               rdata;
  logic                avail;
  logic [lvl_w_lp-1:0] level;

  modport ctrl
  (
    output req, wdata,
    input  rdata, avail, level
  );

  modport store
  (
    input  req, wdata,
    output rdata, avail, level
  );

endinterface

`default_nettype wire

// ==== rtl/apb_csr_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb_csr_ctrl
  #(parameter int fifo_depth_p  = 4
  , parameter int reset_depth_p = 3
  )
  ( input  logic                       aclk
  , input  logic                       arst_n_i
  , input  zynq_shell_pkg::csr_addr_t  paddr_i
  , input  logic                       psel_i
  , input  logic                       penable_i
  , input  logic                       pwrite_i
  , input  zynq_shell_pkg::data_t      pwdata_i
  , output zynq_shell_pkg::data_t      prdata_o
  , output logic                       pready_o
  , output logic                       pslverr_o
  , output logic                       pl_reset_o
  , output zynq_shell_pkg::dram_addr_t dram_base_o
  , output zynq_shell_pkg::rom_addr_t  rom_addr_o
  , input  zynq_shell_pkg::data_t      rom_data_i
  , csr_fifo_if.ctrl                   host_q
  , csr_fifo_if.ctrl                   mc_q
  );

  import zynq_shell_pkg::*;

  localparam int lvl_w_lp = $clog2(fifo_depth_p+1);

  csr_reg_e                 reg_idx;
  logic                     access;
  logic                     err;
  logic                     wr_ok;
  logic                     rd_ok;
  data_t                    sys_reset_r;
  dram_addr_t               dram_base_r;
  rom_addr_t                rom_addr_r;
  logic [reset_depth_p-1:0] rst_chain_r;
  data_t                    status;

  ////////////////////////////////////////////////////////////////////////////
  // apb decode
  ////////////////////////////////////////////////////////////////////////////

  // upper address bits alias onto the same eight words
  assign reg_idx  = csr_reg_e'(paddr_i[4:2]);
  assign access   = psel_i & penable_i;
  assign pready_o = access;

  always_comb
  begin
    err = 1'b0;
    if (access)
    begin
      if (pwrite_i)
      begin
        case (reg_idx)
          reg_rom_data, reg_mc_req, reg_fifo_status: err = 1'b1;
          reg_host_req:                              err = ~host_q.avail;
          default:                                   err = 1'b0;
        endcase
      end
      else
      begin
        case (reg_idx)
          reg_host_req: err = 1'b1;
          reg_mc_req:   err = ~mc_q.avail;
          default:      err = 1'b0;
        endcase
      end
    end
  end

  assign pslverr_o = err;
  assign wr_ok     = access & pwrite_i & ~err;
  assign rd_ok     = access & ~pwrite_i & ~err;

  // queue levels, host in the low byte
  assign status = {16'h0000,
                   {(8-lvl_w_lp){1'b0}}, mc_q.level,
                   {(8-lvl_w_lp){1'b0}}, host_q.level};

  always_comb
  begin
    case (reg_idx)
      reg_sys_reset:   prdata_o = sys_reset_r;
      reg_dram_base:   prdata_o = dram_base_r;
      reg_rom_addr:    prdata_o = data_t'(rom_addr_r);
      reg_rom_data:    prdata_o = rom_data_i;
      reg_mc_req:      prdata_o = mc_q.rdata;
      reg_fifo_status: prdata_o = status;
      default:         prdata_o = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // register file
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      sys_reset_r <= '0;
      dram_base_r <= '0;
      rom_addr_r  <= '0;
    end
    else if (wr_ok)
    begin
      case (reg_idx)
        reg_sys_reset: sys_reset_r <= pwdata_i;
        reg_dram_base: dram_base_r <= pwdata_i;
        reg_rom_addr:  rom_addr_r  <= pwdata_i[$bits(rom_addr_t)-1:0];
        default:       ;
      endcase
    end
  end

  assign dram_base_o = dram_base_r;
  assign rom_addr_o  = rom_addr_r;

  // bit 0 is active low, output falls reset_depth_p edges after the write
  always_ff @(posedge aclk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      rst_chain_r <= '1;
    else
    begin
      rst_chain_r[0] <= ~sys_reset_r[0];
      for (int i = 1; i < reset_depth_p; i++)
        rst_chain_r[i] <= rst_chain_r[i-1];
    end
  end

  assign pl_reset_o = rst_chain_r[reset_depth_p-1];

  // queue side effects only on accesses without error
  assign host_q.req   = wr_ok & (reg_idx == reg_host_req);
  assign host_q.wdata = pwdata_i;
  assign mc_q.req     = rd_ok & (reg_idx == reg_mc_req);
  assign mc_q.wdata   = '0;

endmodule

`default_nettype wire

// ==== rtl/shell_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module shell_fifo
  #(parameter int fifo_depth_p     = 4
  , parameter bit pl_is_producer_p = 1'b0
  )
  ( input  logic                  aclk
  , input  logic                  arst_n_i
  , csr_fifo_if.store             csr_q
  , input  zynq_shell_pkg::data_t pl_data_i
  , input  logic                  pl_v_i
  , output zynq_shell_pkg::data_t pl_data_o
  , output logic                  pl_v_o
  , output logic                  pl_ready_o
  , input  logic                  pl_ready_i
  );

  import zynq_shell_pkg::*;

  localparam int ptr_w_lp = (fifo_depth_p > 1) ? $clog2(fifo_depth_p) : 1;
  localparam int lvl_w_lp = $clog2(fifo_depth_p+1);

  data_t               mem [fifo_depth_p];
  logic [ptr_w_lp-1:0] wr_ptr_r;
  logic [ptr_w_lp-1:0] rd_ptr_r;
  logic [lvl_w_lp-1:0] level_r;
  logic                full;
  logic                empty;
  logic                push;
  logic                pop;
  data_t               wr_data;

  assign full  = (level_r == lvl_w_lp'(fifo_depth_p));
  assign empty = (level_r == '0);

  // role split between the csr side and the fabric side
  if (pl_is_producer_p)
  begin : g_pl_to_ps
    assign push        = pl_v_i & ~full;
    assign wr_data     = pl_data_i;
    assign pop         = csr_q.req;
    assign csr_q.avail = ~empty;
    assign pl_ready_o  = ~full;
    assign pl_v_o      = 1'b0;
  end
  else
  begin : g_ps_to_pl
    assign push        = csr_q.req;
    assign wr_data     = csr_q.wdata;
    assign pop         = ~empty & pl_ready_i;
    assign csr_q.avail = ~full;
    assign pl_ready_o  = 1'b0;
    assign pl_v_o      = ~empty;
  end

  always_ff @(posedge aclk)
  begin
    if (push)
      mem[wr_ptr_r] <= wr_data;
  end

  always_ff @(posedge aclk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      level_r  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr_r <= (wr_ptr_r == ptr_w_lp'(fifo_depth_p-1)) ? '0 : wr_ptr_r + 1'b1;
      if (pop)
        rd_ptr_r <= (rd_ptr_r == ptr_w_lp'(fifo_depth_p-1)) ? '0 : rd_ptr_r + 1'b1;
      case ({push, pop})
        2'b10:   level_r <= level_r + 1'b1;
        2'b01:   level_r <= level_r - 1'b1;
        default: level_r <= level_r;
      endcase
    end
  end

  assign csr_q.rdata = mem[rd_ptr_r];
  assign csr_q.level = level_r;
  assign pl_data_o   = mem[rd_ptr_r];

endmodule

`default_nettype wire

// ==== rtl/config_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module config_rom
  ( input  logic                      aclk
  , input  zynq_shell_pkg::rom_addr_t rom_addr_i
  , output zynq_shell_pkg::data_t     rom_data_o
  );

  import zynq_shell_pkg::*;

  `include "machine_rom.svh"

  data_t rom_data_r;

  // one cycle lookup, address is stable between accesses
  always_ff @(posedge aclk)
  begin
    rom_data_r <= machine_rom_tbl[rom_addr_i];
  end

  assign rom_data_o = rom_data_r;

endmodule

`default_nettype wire

// ==== rtl/dram_addr_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module dram_addr_map
  #(parameter int lg_num_cache_p = 3
  )
  ( input  logic                        aclk
  , input  logic                        arst_n_i
  , input  logic                        pl_reset_i
  , input  logic                        dma_v_i
  , input  zynq_shell_pkg::cache_id_t   dma_cache_id_i
  , input  zynq_shell_pkg::cache_addr_t dma_addr_i
  , input  zynq_shell_pkg::dram_addr_t  dram_base_i
  , output zynq_shell_pkg::dram_addr_t  dram_addr_o
  , output logic                        dram_v_o
  );

  import zynq_shell_pkg::*;

  localparam int low_bits_lp = dram_span_bits - lg_num_cache_p;
  localparam int pad_bits_lp = $bits(dram_addr_t) - dram_span_bits;

  dram_addr_t hash_addr;
  dram_addr_t dram_addr_r;
  logic       dram_v_r;

  // cache id sits directly above the per-cache window
  assign hash_addr = {{pad_bits_lp{1'b0}},
                      dma_cache_id_i[lg_num_cache_p-1:0],
                      dma_addr_i[low_bits_lp-1:0]};

  always_ff @(posedge aclk)
  begin
    if (dma_v_i)
      dram_addr_r <= hash_addr + dram_base_i;
  end

  always_ff @(posedge aclk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      dram_v_r <= 1'b0;
    else if (pl_reset_i)
      dram_v_r <= 1'b0;
    else
      dram_v_r <= dma_v_i;
  end

  assign dram_addr_o = dram_addr_r;
  assign dram_v_o    = dram_v_r;

endmodule

`default_nettype wire

// ==== rtl/zynq_shell_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module zynq_shell_top
  #(parameter int fifo_depth_p   = 4
  , parameter int reset_depth_p  = 3
  , parameter int lg_num_cache_p = 3
  )
  ( input  logic                        aclk
  , input  logic                        arst_n_i
  // apb from the processor
  , input  zynq_shell_pkg::csr_addr_t   paddr_i
  , input  logic                        psel_i
  , input  logic                        penable_i
  , input  logic                        pwrite_i
  , input  zynq_shell_pkg::data_t       pwdata_i
  , output zynq_shell_pkg::data_t       prdata_o
  , output logic                        pready_o
  , output logic                        pslverr_o
  , output logic                        pl_reset_o
  // host requests toward the fabric
  , output zynq_shell_pkg::data_t       host_req_o
  , output logic                        host_req_v_o
  , input  logic                        host_req_ready_i
  // manycore requests toward the processor
  , input  zynq_shell_pkg::data_t       mc_req_i
  , input  logic                        mc_req_v_i
  , output logic                        mc_req_ready_o
  // cache dma address
  , input  logic                        dma_v_i
  , input  zynq_shell_pkg::cache_id_t   dma_cache_id_i
  , input  zynq_shell_pkg::cache_addr_t dma_addr_i
  , output zynq_shell_pkg::dram_addr_t  dram_addr_o
  , output logic                        dram_v_o
  );

  import zynq_shell_pkg::*;

  dram_addr_t dram_base;
  rom_addr_t  rom_addr;
  data_t      rom_data;

  csr_fifo_if #(.fifo_depth_p(fifo_depth_p)) host_q_if ();
  csr_fifo_if #(.fifo_depth_p(fifo_depth_p)) mc_q_if ();

  apb_csr_ctrl
   #(.fifo_depth_p(fifo_depth_p)
    ,.reset_depth_p(reset_depth_p)
    )
   i_csr
    (.aclk(aclk), .arst_n_i(arst_n_i)
    ,.paddr_i(paddr_i), .psel_i(psel_i), .penable_i(penable_i)
    ,.pwrite_i(pwrite_i), .pwdata_i(pwdata_i)
    ,.prdata_o(prdata_o), .pready_o(pready_o), .pslverr_o(pslverr_o)
    ,.pl_reset_o(pl_reset_o), .dram_base_o(dram_base)
    ,.rom_addr_o(rom_addr), .rom_data_i(rom_data)
    ,.host_q(host_q_if.ctrl), .mc_q(mc_q_if.ctrl)
    );

  shell_fifo
   #(.fifo_depth_p(fifo_depth_p), .pl_is_producer_p(1'b0))
   i_host_fifo
    (.aclk(aclk), .arst_n_i(arst_n_i), .csr_q(host_q_if.store)
    ,.pl_data_i('0), .pl_v_i(1'b0)
    ,.pl_data_o(host_req_o), .pl_v_o(host_req_v_o), .pl_ready_o()
    ,.pl_ready_i(host_req_ready_i)
    );

  shell_fifo
   #(.fifo_depth_p(fifo_depth_p), .pl_is_producer_p(1'b1))
   i_mc_fifo
    (.aclk(aclk), .arst_n_i(arst_n_i), .csr_q(mc_q_if.store)
    ,.pl_data_i(mc_req_i), .pl_v_i(mc_req_v_i)
    ,.pl_data_o(), .pl_v_o(), .pl_ready_o(mc_req_ready_o)
    ,.pl_ready_i(1'b0)
    );

  config_rom i_rom
    (.aclk(aclk), .rom_addr_i(rom_addr), .rom_data_o(rom_data));

  dram_addr_map
   #(.lg_num_cache_p(lg_num_cache_p))
   i_addr_map
    (.aclk(aclk), .arst_n_i(arst_n_i), .pl_reset_i(pl_reset_o)
    ,.dma_v_i(dma_v_i), .dma_cache_id_i(dma_cache_id_i), .dma_addr_i(dma_addr_i)
    ,.dram_base_i(dram_base), .dram_addr_o(dram_addr_o), .dram_v_o(dram_v_o)
    );

endmodule

`default_nettype wire

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
  #(parameter int period_p = 40
  )
  ( output logic clk_o
  );

  initial
  begin
    clk_o = 1'b0;
    forever
      #(period_p/2) clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

// ==== verification/tb_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_checker
  #(parameter int fifo_depth_p = 4
  )
  ( input  logic                       clk_i
  , input  logic                       arst_n_i
  , input  logic                       psel_i
  , input  logic                       penable_i
  , input  zynq_shell_pkg::data_t      prdata_i
  , input  logic                       pready_i
  , input  logic                       pslverr_i
  , input  logic                       pl_reset_i
  , input  zynq_shell_pkg::data_t      host_req_i
  , input  logic                       host_req_v_i
  , input  logic                       host_req_ready_i
  , input  zynq_shell_pkg::data_t      mc_req_i
  , input  logic                       mc_req_v_i
  , input  logic                       mc_req_ready_i
  , input  logic                       dma_v_i
  , input  zynq_shell_pkg::dram_addr_t dram_addr_i
  , input  logic                       dram_v_i
  );

  import zynq_shell_pkg::*;

  bit         apb_err_q  [$];
  bit         apb_chk_q  [$];
  data_t      apb_data_q [$];
  data_t      host_q     [$];
  data_t      mc_q       [$];
  dram_addr_t dram_q     [$];
  int         errors = 0;
  int         checks = 0;
  int         mc_accepted = 0;
  logic       pl_reset_exp = 1'b1;
  logic       pl_reset_next = 1'b1;
  int         pl_reset_cnt = 0;
  logic       dma_v_d = 1'b0;

  task automatic expect_apb(input bit err, input bit chk, input data_t data);
    apb_err_q.push_back(err);
    apb_chk_q.push_back(chk);
    apb_data_q.push_back(data);
  endtask

  task automatic expect_host(input data_t data);
    host_q.push_back(data);
  endtask

  task automatic expect_dram(input dram_addr_t addr);
    dram_q.push_back(addr);
  endtask

  // cycles counts rising edges after the access cycle, checks run on falling edges
  task automatic expect_pl_reset(input logic val, input int cycles);
    pl_reset_next = val;
    pl_reset_cnt  = cycles + 1;
  endtask

  function automatic int host_level();
    return host_q.size();
  endfunction

  function automatic int mc_level();
    return mc_q.size();
  endfunction

  function automatic data_t mc_head();
    return (mc_q.size() != 0) ? mc_q[0] : '0;
  endfunction

  task automatic pop_mc();
    void'(mc_q.pop_front());
  endtask

  function automatic int pending();
    return apb_err_q.size() + dram_q.size() + host_q.size() + mc_q.size();
  endfunction

  task automatic check_eq(input string what, input data_t got, input data_t exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic report(input string what);
    errors++;
    $display("%0t: %s", $time, what);
  endtask

  task automatic final_check();
    if (pending() != 0)
      report("some expected responses never arrived from the DUT");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // outputs are settled mid-cycle
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i)
  begin
    if (arst_n_i)
    begin
      if (pl_reset_cnt > 0)
      begin
        pl_reset_cnt--;
        if (pl_reset_cnt == 0)
          pl_reset_exp = pl_reset_next;
      end
      check_eq("pl_reset_o", data_t'(pl_reset_i), data_t'(pl_reset_exp));

      if (psel_i && penable_i)
      begin
        if (apb_err_q.size() == 0)
          report("APB access phase seen with no response expected");
        else
        begin
          check_eq("pready_o", data_t'(pready_i), 32'd1);
          check_eq("pslverr_o", data_t'(pslverr_i), data_t'(apb_err_q[0]));
          if (apb_chk_q[0])
            check_eq("prdata_o", prdata_i, apb_data_q[0]);
          void'(apb_err_q.pop_front());
          void'(apb_chk_q.pop_front());
          void'(apb_data_q.pop_front());
        end
      end

      check_eq("host_req_v_o", data_t'(host_req_v_i), data_t'(host_q.size() != 0));
      if (host_req_v_i && host_req_ready_i && host_q.size() != 0)
        check_eq("host_req_o", host_req_i, host_q.pop_front());

      // accepted words land in the queue on the next rising edge
      check_eq("mc_req_ready_o", data_t'(mc_req_ready_i),
               data_t'(mc_q.size() < fifo_depth_p));
      if (mc_req_v_i && (mc_q.size() < fifo_depth_p))
      begin
        mc_q.push_back(mc_req_i);
        mc_accepted++;
      end

      // one cycle of latency through the address map
      check_eq("dram_v_o", data_t'(dram_v_i), data_t'(dma_v_d));
      if (dram_v_i)
      begin
        if (dram_q.size() == 0)
          report("dram_v_o rose with no address in flight");
        else
          check_eq("dram_addr_o", dram_addr_i, dram_q.pop_front());
      end
      dma_v_d = dma_v_i & ~pl_reset_i;
    end
  end

endmodule

`default_nettype wire

// ==== verification/zynq_shell_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module zynq_shell_props
  ( input logic clk_i
  , input logic arst_n_i
  , input logic psel_i
  , input logic penable_i
  , input logic pready_i
  , input logic pslverr_i
  , input logic host_req_v_i
  , input logic host_req_ready_i
  );

  int fail_count = 0;

  // no wait states
  a_pready_in_access: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (psel_i && penable_i) |-> pready_i)
    else
    begin
      fail_count++;
      $error("pready low during an APB access phase");
    end

  a_pslverr_in_access: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pslverr_i |-> (psel_i && penable_i))
    else
    begin
      fail_count++;
      $error("pslverr high outside an APB access phase");
    end

  // host valid drops only after a handshake on the fabric side
  a_host_v_fall: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $fell(host_req_v_i) |-> $past(host_req_ready_i))
    else
    begin
      fail_count++;
      $error("host queue valid fell without a pop");
    end

endmodule

bind zynq_shell_top zynq_shell_props
  i_props
  (.clk_i(aclk), .arst_n_i(arst_n_i), .psel_i(psel_i), .penable_i(penable_i)
  ,.pready_i(pready_o), .pslverr_i(pslverr_o)
  ,.host_req_v_i(host_req_v_o), .host_req_ready_i(host_req_ready_i)
  );

`default_nettype wire

// ==== verification/tb_zynq_shell.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_zynq_shell;

  import zynq_shell_pkg::*;

  `include "machine_rom.svh"

  localparam int fifo_depth_lp   = 4;
  localparam int reset_depth_lp  = 3;
  localparam int lg_num_cache_lp = 3;
  localparam int max_cycles_lp   = 2000;
  localparam int mc_words_lp     = 20;
  localparam int dma_words_lp    = 30;

  logic        aclk;
  logic        arst_n;
  csr_addr_t   paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  data_t       pwdata;
  data_t       prdata;
  logic        pready;
  logic        pslverr;
  logic        pl_reset;
  data_t       host_req;
  logic        host_req_v;
  logic        host_req_ready;
  data_t       mc_req;
  logic        mc_req_v;
  logic        mc_req_ready;
  logic        dma_v;
  cache_id_t   dma_cache_id;
  cache_addr_t dma_addr;
  dram_addr_t  dram_addr;
  logic        dram_v;

  integer      seed = 91;
  int          cycles = 0;
  int          dma_sent;
  int          total_errors;
  data_t       sh_sys_reset = '0;
  data_t       sh_dram_base = '0;
  rom_addr_t   sh_rom_addr = '0;
  int          mc_popped = 0;
  data_t       mc_words [mc_words_lp];
  bit          mc_valid_pat [32];
  int          gap_pat [32];

  tb_clk_gen #(.period_p(40)) i_clk (.clk_o(aclk));

  zynq_shell_top
   #(.fifo_depth_p(fifo_depth_lp)
    ,.reset_depth_p(reset_depth_lp)
    ,.lg_num_cache_p(lg_num_cache_lp)
    )
   i_dut
    (.aclk(aclk), .arst_n_i(arst_n)
    ,.paddr_i(paddr), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite)
    ,.pwdata_i(pwdata), .prdata_o(prdata), .pready_o(pready), .pslverr_o(pslverr)
    ,.pl_reset_o(pl_reset)
    ,.host_req_o(host_req), .host_req_v_o(host_req_v), .host_req_ready_i(host_req_ready)
    ,.mc_req_i(mc_req), .mc_req_v_i(mc_req_v), .mc_req_ready_o(mc_req_ready)
    ,.dma_v_i(dma_v), .dma_cache_id_i(dma_cache_id), .dma_addr_i(dma_addr)
    ,.dram_addr_o(dram_addr), .dram_v_o(dram_v)
    );

  tb_checker
   #(.fifo_depth_p(fifo_depth_lp))
   i_chk
    (.clk_i(aclk), .arst_n_i(arst_n), .psel_i(psel), .penable_i(penable)
    ,.prdata_i(prdata), .pready_i(pready), .pslverr_i(pslverr), .pl_reset_i(pl_reset)
    ,.host_req_i(host_req), .host_req_v_i(host_req_v), .host_req_ready_i(host_req_ready)
    ,.mc_req_i(mc_req), .mc_req_v_i(mc_req_v), .mc_req_ready_i(mc_req_ready)
    ,.dma_v_i(dma_v), .dram_addr_i(dram_addr), .dram_v_i(dram_v)
    );

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic dram_addr_t ref_dram_addr(dram_addr_t base, cache_id_t id,
                                               cache_addr_t addr);
    int         low_bits;
    dram_addr_t low_mask;
    low_bits = dram_span_bits - lg_num_cache_lp;
    low_mask = (dram_addr_t'(1) << low_bits) - 1;
    return ((dram_addr_t'(id) << low_bits) | (dram_addr_t'(addr) & low_mask)) + base;
  endfunction

  function automatic bit ref_error(bit write, csr_reg_e idx);
    bit err;
    if (write)
      err = (idx == reg_rom_data) || (idx == reg_mc_req) || (idx == reg_fifo_status)
            || ((idx == reg_host_req) && (i_chk.host_level() >= fifo_depth_lp));
    else
      err = (idx == reg_host_req) || ((idx == reg_mc_req) && (i_chk.mc_level() == 0));
    return err;
  endfunction

  function automatic data_t ref_rdata(csr_reg_e idx);
    data_t d;
    case (idx)
      reg_sys_reset:   d = sh_sys_reset;
      reg_dram_base:   d = sh_dram_base;
      reg_rom_addr:    d = data_t'(sh_rom_addr);
      reg_rom_data:    d = machine_rom_tbl[sh_rom_addr];
      reg_mc_req:      d = i_chk.mc_head();
      reg_fifo_status: d = {16'h0000, 8'(i_chk.mc_level()), 8'(i_chk.host_level())};
      default:         d = '0;
    endcase
    return d;
  endfunction

  task automatic update_model(input bit write, input csr_reg_e idx, input data_t wdata);
    if (write)
    begin
      case (idx)
        reg_sys_reset:
        begin
          sh_sys_reset = wdata;
          i_chk.expect_pl_reset(~wdata[0], reset_depth_lp);
        end
        reg_dram_base: sh_dram_base = wdata;
        reg_rom_addr:  sh_rom_addr = rom_addr_t'(wdata);
        reg_host_req:  i_chk.expect_host(wdata);
        default:       ;
      endcase
    end
    else if (idx == reg_mc_req)
    begin
      i_chk.pop_mc();
      mc_popped++;
    end
  endtask

  // starts and ends 2 ns after a rising edge
  task automatic apb_access(input bit write, input csr_reg_e idx, input data_t wdata);
    bit    exp_err;
    data_t exp_data;
    paddr   = csr_addr_t'({idx, 2'b00});
    pwrite  = write;
    pwdata  = wdata;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge aclk);
    #2;
    penable  = 1'b1;
    exp_err  = ref_error(write, idx);
    exp_data = ref_rdata(idx);
    i_chk.expect_apb(exp_err, !write && !exp_err, exp_data);
    @(posedge aclk);
    #2;
    psel    = 1'b0;
    penable = 1'b0;
    if (!exp_err)
      update_model(write, idx, wdata);
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge aclk);
      #2;
    end
  endtask

  task automatic drain_host_queue();
    host_req_ready = 1'b1;
    while (host_req_v)
      idle(1);
  endtask

  task automatic drive_mc_words();
    int slot;
    slot = 0;
    while (i_chk.mc_accepted < mc_words_lp)
    begin
      mc_req_v = mc_valid_pat[slot % 32];
      mc_req   = mc_words[i_chk.mc_accepted];
      idle(1);
      slot++;
    end
    mc_req_v = 1'b0;
  endtask

  task automatic read_mc_words();
    int n;
    n = 0;
    while (mc_popped < mc_words_lp)
    begin
      idle(gap_pat[n % 32]);
      if (n % 3 == 2)
        apb_access(1'b0, reg_fifo_status, '0);
      else
        apb_access(1'b0, reg_mc_req, '0);
      n++;
    end
  endtask

  initial
  begin
    while (cycles < max_cycles_lp)
    begin
      @(posedge aclk);
      cycles++;
    end
    $display("timeout: the run did not finish within %0d clock cycles", max_cycles_lp);
    $display("** FAIL **");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    arst_n         = 1'b0;
    paddr          = '0;
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    pwdata         = '0;
    host_req_ready = 1'b0;
    mc_req         = '0;
    mc_req_v       = 1'b0;
    dma_v          = 1'b0;
    dma_cache_id   = '0;
    dma_addr       = '0;
    for (int i = 0; i < mc_words_lp; i++)
      mc_words[i] = $random(seed);
    for (int i = 0; i < 32; i++)
    begin
      mc_valid_pat[i] = $random(seed);
      gap_pat[i]      = $random(seed) & 3;
    end
    repeat (3) @(posedge aclk);
    #2;
    arst_n = 1'b1;

    // pl reset release
    idle(2);
    apb_access(1'b1, reg_sys_reset, 32'h0000_0001);

    // configuration rom
    for (int i = 0; i < rom_els; i++)
    begin
      apb_access(1'b1, reg_rom_addr, data_t'(i));
      apb_access(1'b0, reg_rom_data, '0);
    end

    // host queue overflow then drain in order
    for (int i = 0; i < fifo_depth_lp + 1; i++)
      apb_access(1'b1, reg_host_req, $random(seed));
    drain_host_queue();

    // manycore queue with concurrent fill and drain
    fork
      drive_mc_words();
      read_mc_words();
    join
    apb_access(1'b0, reg_mc_req, '0);
    apb_access(1'b0, reg_fifo_status, '0);

    // dram address map
    apb_access(1'b1, reg_dram_base, $random(seed));
    dma_sent = 0;
    while (dma_sent < dma_words_lp)
    begin
      dma_v        = $random(seed);
      dma_cache_id = $random(seed);
      dma_addr     = $random(seed);
      if (dma_v)
      begin
        i_chk.expect_dram(ref_dram_addr(sh_dram_base, dma_cache_id, dma_addr));
        dma_sent++;
      end
      idle(1);
    end
    dma_v = 1'b0;
    while (dram_v)
      idle(1);

    // illegal accesses leave state alone
    host_req_ready = 1'b0;
    apb_access(1'b1, reg_host_req, $random(seed));
    apb_access(1'b1, reg_host_req, $random(seed));
    apb_access(1'b1, reg_rom_data, 32'hffff_ffff);
    apb_access(1'b1, reg_mc_req, 32'hffff_ffff);
    apb_access(1'b1, reg_fifo_status, 32'hffff_ffff);
    apb_access(1'b0, reg_host_req, '0);
    apb_access(1'b0, reg_fifo_status, '0);
    apb_access(1'b0, reg_rom_data, '0);
    apb_access(1'b0, reg_sys_reset, '0);
    apb_access(1'b0, reg_dram_base, '0);
    apb_access(1'b0, reg_rom_addr, '0);
    drain_host_queue();
    idle(2);

    i_chk.final_check();
    total_errors = i_chk.errors + i_dut.i_props.fail_count;
    $display("checks %0d, checker errors %0d, assertion failures %0d",
             i_chk.checks, i_chk.errors, i_dut.i_props.fail_count);
    if (total_errors == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
rtl/zynq_shell_pkg.sv
rtl/csr_fifo_if.sv
rtl/apb_csr_ctrl.sv
rtl/shell_fifo.sv
rtl/config_rom.sv
rtl/dram_addr_map.sv
rtl/zynq_shell_top.sv
verification/tb_clk_gen.sv
verification/tb_checker.sv
verification/zynq_shell_props.sv
verification/tb_zynq_shell.sv
